//--- common/cache_pkg.sv
// ----------------------------------------
// cache package: widths, address views,
// request codes and execute states
// ----------------------------------------
package cache_pkg;

  localparam int ADDR_W = 64;
  localparam int DATA_W = 64;
  localparam int LINE_W = 512;       // eight words per line
  localparam int OFFS_W = 3;         // word within line
  localparam int IDX_W  = 6;         // room for 64 sets
  localparam int TAG_W  = ADDR_W - IDX_W - OFFS_W - 3;

  localparam logic OP_READ  = 1'b0;
  localparam logic OP_WRITE = 1'b1;

  // upper half of every exerciser write word
  localparam logic [DATA_W-1:0] PATTERN_HI = 64'h01234567_0000_0000;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [IDX_W-1:0]  index;
    logic [OFFS_W-1:0] offset;
    logic [2:0]        byte_sel;   // always zero, word aligned
  } cache_addr_fields_t;

  typedef union packed {
    logic [ADDR_W-1:0]  raw;
    cache_addr_fields_t f;
  } cache_addr_u;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITE_BACK,
    ST_FILL,
    ST_UPDATE
  } cache_state_e;

endpackage

//--- common/cache_if.sv
// ----------------------------------------
// cache stage interfaces: tag lookup and
// line data paths
// ----------------------------------------
`timescale 1ns/1ps

interface cache_lookup_if import cache_pkg::*; #(parameter int NUM_SETS = 16) ();
  localparam int SET_W  = $clog2(NUM_SETS);
  localparam int VTAG_W = ADDR_W - SET_W - OFFS_W - 3;

  logic              req_valid;
  logic              op;
  cache_addr_u       addr;
  logic [DATA_W-1:0] wdata;
  logic              hit;
  logic              dirty;
  logic [VTAG_W-1:0] vtag;     // tag of the line now in the set
  logic              tag_we;
  logic              set_dirty;
  logic              clr_dirty;
  logic              done;     // request finished, decode may capture again

  modport decode (output req_valid, op, addr, wdata, hit, dirty, vtag,
                  input  tag_we, set_dirty, clr_dirty, done);
  modport execute (input  req_valid, op, addr, wdata, hit, dirty, vtag,
                   output tag_we, set_dirty, clr_dirty, done);
endinterface

interface cache_data_if import cache_pkg::*; #(parameter int NUM_SETS = 16) ();
  localparam int SET_W = $clog2(NUM_SETS);

  logic              line_we;
  logic [LINE_W-1:0] fill_line;
  logic              word_we;
  logic [SET_W-1:0]  index;
  logic [OFFS_W-1:0] offset;
  logic [DATA_W-1:0] wdata;
  logic              ack_pulse;
  logic [LINE_W-1:0] victim_line;

  modport execute (output line_we, fill_line, word_we, index, offset, wdata, ack_pulse,
                   input  victim_line);
  modport result (input  line_we, fill_line, word_we, index, offset, wdata, ack_pulse,
                  output victim_line);
endinterface

//--- cache/cache_decode.sv
// ----------------------------------------
// cache decode stage: request capture,
// tag/valid/dirty arrays and hit check
// ----------------------------------------
`timescale 1ns/1ps

module cache_decode import cache_pkg::*; #(
  parameter int NUM_SETS = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_req,
  input  logic              i_op,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [DATA_W-1:0] i_wdata,
  cache_lookup_if.decode    lk
);

  localparam int SET_W  = $clog2(NUM_SETS);
  localparam int VTAG_W = ADDR_W - SET_W - OFFS_W - 3;

  logic [VTAG_W-1:0]   tag_arr [NUM_SETS];
  logic [NUM_SETS-1:0] valid_bits;
  logic [NUM_SETS-1:0] dirty_bits;
  logic                req_taken;   // this req level already served
  logic                capture;
  logic [SET_W-1:0]    set_idx;
  logic [VTAG_W-1:0]   req_tag;

  assign capture = i_req && !lk.req_valid && !req_taken;

  // set from the field view, tag straight off the raw word
  assign set_idx = lk.addr.f.index[SET_W-1:0];
  assign req_tag = lk.addr.raw[ADDR_W-1 -: VTAG_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      lk.req_valid <= 1'b0;
      req_taken    <= 1'b0;
    end else begin
      if (lk.done)
        lk.req_valid <= 1'b0;
      else if (capture)
        lk.req_valid <= 1'b1;
      // exerciser keeps req up through the ack, wait for it to drop
      if (!i_req)
        req_taken <= 1'b0;
      else if (capture)
        req_taken <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      lk.op       <= i_op;
      lk.addr.raw <= i_addr;
      lk.wdata    <= i_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (lk.tag_we)
      tag_arr[set_idx] <= req_tag;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (lk.tag_we) begin
        valid_bits[set_idx] <= 1'b1;
        dirty_bits[set_idx] <= 1'b0;   // fresh line from memory
      end
      if (lk.clr_dirty)
        dirty_bits[set_idx] <= 1'b0;   // written back
      if (lk.set_dirty)
        dirty_bits[set_idx] <= 1'b1;
    end
  end

  assign lk.hit   = valid_bits[set_idx] && (tag_arr[set_idx] == req_tag);
  assign lk.dirty = valid_bits[set_idx] && dirty_bits[set_idx];
  assign lk.vtag  = tag_arr[set_idx];

endmodule

//--- cache/cache_execute.sv
// ----------------------------------------
// cache execute stage: miss, write-back
// and fill control on the line port
// ----------------------------------------
`timescale 1ns/1ps

module cache_execute import cache_pkg::*; #(
  parameter int NUM_SETS = 16
) (
  input  logic              clk,
  input  logic              rst,
  cache_lookup_if.execute   lk,
  cache_data_if.execute     dt,
  output logic              o_mem_valid,
  output logic              o_mem_op,
  output logic [ADDR_W-1:0] o_mem_addr,
  output logic [LINE_W-1:0] o_mem_wdata,
  input  logic              i_mem_ready,
  input  logic [LINE_W-1:0] i_mem_rdata
);

  localparam int SET_W = $clog2(NUM_SETS);
  localparam int LOW_W = OFFS_W + 3;   // byte address bits inside a line

  cache_state_e      state;
  cache_state_e      state_nxt;
  logic              serve;
  logic              wr_serve;
  logic              wb_done;
  logic              fill_done;
  logic [SET_W-1:0]  set_idx;
  logic [ADDR_W-1:0] line_addr;
  logic [ADDR_W-1:0] victim_addr;

  assign set_idx     = lk.addr.f.index[SET_W-1:0];
  assign line_addr   = {lk.addr.f.tag, lk.addr.f.index, {LOW_W{1'b0}}};
  assign victim_addr = {lk.vtag, set_idx, {LOW_W{1'b0}}};   // rebuilt from stored tag

  // a hit is answered straight from idle, a miss after its fill
  assign serve     = ((state == ST_IDLE) && lk.req_valid && lk.hit) || (state == ST_UPDATE);
  assign wr_serve  = serve && (lk.op == OP_WRITE);
  assign wb_done   = (state == ST_WRITE_BACK) && i_mem_ready;
  assign fill_done = (state == ST_FILL) && i_mem_ready;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:       if (lk.req_valid && !lk.hit) state_nxt = ST_LOOKUP;
      ST_LOOKUP:     state_nxt = lk.dirty ? ST_WRITE_BACK : ST_FILL;
      ST_WRITE_BACK: if (i_mem_ready) state_nxt = ST_LOOKUP;   // look again, now clean
      ST_FILL:       if (i_mem_ready) state_nxt = ST_UPDATE;
      ST_UPDATE:     state_nxt = ST_IDLE;
      default:       state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ST_IDLE;
      o_mem_valid <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == ST_LOOKUP)
        o_mem_valid <= 1'b1;
      else if (o_mem_valid && i_mem_ready)
        o_mem_valid <= 1'b0;
    end
  end

  // line request is set up once and held until ready
  always_ff @(posedge clk) begin
    if (state == ST_LOOKUP) begin
      o_mem_op    <= lk.dirty ? OP_WRITE : OP_READ;
      o_mem_addr  <= lk.dirty ? victim_addr : line_addr;
      o_mem_wdata <= dt.victim_line;
    end
  end

  assign lk.tag_we    = fill_done;
  assign lk.clr_dirty = wb_done;
  assign lk.set_dirty = wr_serve;
  assign lk.done      = serve;

  assign dt.line_we   = fill_done;
  assign dt.fill_line = i_mem_rdata;
  assign dt.word_we   = wr_serve;
  assign dt.index     = set_idx;
  assign dt.offset    = lk.addr.f.offset;
  assign dt.wdata     = lk.wdata;
  assign dt.ack_pulse = serve;

endmodule

//--- cache/cache_result.sv
// ----------------------------------------
// cache result stage: line data array,
// word merge and read response
// ----------------------------------------
`timescale 1ns/1ps

module cache_result import cache_pkg::*; #(
  parameter int NUM_SETS = 16
) (
  input  logic              clk,
  input  logic              rst,
  cache_data_if.result      dt,
  output logic [DATA_W-1:0] o_rdata,
  output logic              o_ack
);

  logic [LINE_W-1:0] line_arr [NUM_SETS];
  logic [LINE_W-1:0] cur_line;
  logic [LINE_W-1:0] merged_line;

  assign cur_line = line_arr[dt.index];

  // replace one word of the current line
  always_comb begin
    merged_line = cur_line;
    merged_line[dt.offset*DATA_W +: DATA_W] = dt.wdata;
  end

  always_ff @(posedge clk) begin
    if (dt.line_we)
      line_arr[dt.index] <= dt.fill_line;
    else if (dt.word_we)
      line_arr[dt.index] <= merged_line;
  end

  assign dt.victim_line = cur_line;   // goes out on a write-back

  always_ff @(posedge clk) begin
    if (dt.ack_pulse)
      o_rdata <= cur_line[dt.offset*DATA_W +: DATA_W];
  end

  always_ff @(posedge clk) begin
    if (rst)
      o_ack <= 1'b0;
    else
      o_ack <= dt.ack_pulse;   // one cycle, lines up with rdata
  end

endmodule

//--- cache/cache_core.sv
// ----------------------------------------
// direct-mapped write-back data cache
// ----------------------------------------
`timescale 1ns/1ps

module cache_core import cache_pkg::*; #(
  parameter int NUM_SETS = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_req,
  input  logic              i_op,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [DATA_W-1:0] i_wdata,
  output logic [DATA_W-1:0] o_rdata,
  output logic              o_ack,
  output logic              o_mem_valid,
  output logic              o_mem_op,
  output logic [ADDR_W-1:0] o_mem_addr,
  output logic [LINE_W-1:0] o_mem_wdata,
  input  logic              i_mem_ready,
  input  logic [LINE_W-1:0] i_mem_rdata
);

  cache_lookup_if #(.NUM_SETS(NUM_SETS)) lk ();
  cache_data_if   #(.NUM_SETS(NUM_SETS)) dt ();

  cache_decode #(.NUM_SETS(NUM_SETS)) u_decode (
    .clk     (clk),
    .rst     (rst),
    .i_req   (i_req),
    .i_op    (i_op),
    .i_addr  (i_addr),
    .i_wdata (i_wdata),
    .lk      (lk)
  );

  cache_execute #(.NUM_SETS(NUM_SETS)) u_execute (
    .clk         (clk),
    .rst         (rst),
    .lk          (lk),
    .dt          (dt),
    .o_mem_valid (o_mem_valid),
    .o_mem_op    (o_mem_op),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .i_mem_ready (i_mem_ready),
    .i_mem_rdata (i_mem_rdata)
  );

  cache_result #(.NUM_SETS(NUM_SETS)) u_result (
    .clk     (clk),
    .rst     (rst),
    .dt      (dt),
    .o_rdata (o_rdata),
    .o_ack   (o_ack)
  );

endmodule

//--- design/cache_exerciser.sv
// ----------------------------------------
// cache traffic exerciser: write/read-back
// sweep then full read pass, with check
// ----------------------------------------
`timescale 1ns/1ps

module cache_exerciser import cache_pkg::*; #(
  parameter logic [ADDR_W-1:0] BASE_ADDR = 64'h0000_0000_8000_0000,
  parameter int                NUM_WORDS = 512,
  parameter int                GAP       = 5
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_start,
  output logic              o_req,
  output logic              o_op,
  output logic [ADDR_W-1:0] o_addr,
  output logic [DATA_W-1:0] o_wdata,
  input  logic [DATA_W-1:0] i_rdata,
  input  logic              i_ack,
  output logic              o_busy,
  output logic              o_done,
  output logic              o_error,
  output logic [ADDR_W-1:0] o_err_addr
);

  localparam int                CNT_W     = $clog2(GAP + 2);
  localparam logic [ADDR_W-1:0] LAST_ADDR = BASE_ADDR + ADDR_W'(8 * (NUM_WORDS - 1));

  logic [CNT_W-1:0] gap_cnt;
  logic             pass2;       // read-only sweep
  logic             hs;
  logic             mismatch;
  logic             last_word;

  assign o_wdata   = PATTERN_HI | o_addr;   // also the expected read data
  assign hs        = o_req && i_ack;
  assign mismatch  = (o_op == OP_READ) && (i_rdata != o_wdata);
  assign last_word = (o_addr == LAST_ADDR);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_req   <= 1'b0;
      o_op    <= OP_WRITE;
      o_addr  <= BASE_ADDR;
      o_busy  <= 1'b0;
      o_done  <= 1'b0;
      o_error <= 1'b0;
      pass2   <= 1'b0;
      gap_cnt <= '0;
    end else if (!o_busy) begin
      if (i_start) begin
        o_busy  <= 1'b1;
        o_done  <= 1'b0;
        o_error <= 1'b0;
        o_op    <= OP_WRITE;
        o_addr  <= BASE_ADDR;
        pass2   <= 1'b0;
        gap_cnt <= '0;
      end
    end else if (hs) begin
      o_req   <= 1'b0;
      gap_cnt <= '0;
      if (mismatch) begin
        o_error <= 1'b1;    // stop on the first bad word
        o_busy  <= 1'b0;
      end else if (o_op == OP_WRITE) begin
        o_op <= OP_READ;    // read back the same word
      end else if (!last_word) begin
        o_addr <= o_addr + 64'd8;
        o_op   <= pass2 ? OP_READ : OP_WRITE;
      end else if (!pass2) begin
        pass2  <= 1'b1;
        o_addr <= BASE_ADDR;
      end else begin
        o_done <= 1'b1;
        o_busy <= 1'b0;
      end
    end else if (!o_req) begin
      // idle gap before each request
      if (gap_cnt >= CNT_W'(GAP))
        o_req <= 1'b1;
      else
        gap_cnt <= gap_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (o_busy && hs && mismatch)
      o_err_addr <= o_addr;
  end

endmodule

//--- design/cache_subsys_top.sv
// ----------------------------------------
// cache subsystem: exerciser driving the
// cache core, line port to memory
// ----------------------------------------
`timescale 1ns/1ps

module cache_subsys_top import cache_pkg::*; #(
  parameter int                NUM_SETS  = 16,
  parameter logic [ADDR_W-1:0] BASE_ADDR = 64'h0000_0000_8000_0000,
  parameter int                NUM_WORDS = 512,
  parameter int                GAP       = 5
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_start,
  output logic              o_mem_valid,
  output logic              o_mem_op,
  output logic [ADDR_W-1:0] o_mem_addr,
  output logic [LINE_W-1:0] o_mem_wdata,
  input  logic              i_mem_ready,
  input  logic [LINE_W-1:0] i_mem_rdata,
  output logic              o_busy,
  output logic              o_done,
  output logic              o_error,
  output logic [ADDR_W-1:0] o_err_addr
);

  logic              req;
  logic              op;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;
  logic              ack;

  cache_exerciser #(
    .BASE_ADDR (BASE_ADDR),
    .NUM_WORDS (NUM_WORDS),
    .GAP       (GAP)
  ) u_exerciser (
    .clk        (clk),
    .rst        (rst),
    .i_start    (i_start),
    .o_req      (req),
    .o_op       (op),
    .o_addr     (addr),
    .o_wdata    (wdata),
    .i_rdata    (rdata),
    .i_ack      (ack),
    .o_busy     (o_busy),
    .o_done     (o_done),
    .o_error    (o_error),
    .o_err_addr (o_err_addr)
  );

  cache_core #(.NUM_SETS(NUM_SETS)) u_cache_core (
    .clk         (clk),
    .rst         (rst),
    .i_req       (req),
    .i_op        (op),
    .i_addr      (addr),
    .i_wdata     (wdata),
    .o_rdata     (rdata),
    .o_ack       (ack),
    .o_mem_valid (o_mem_valid),
    .o_mem_op    (o_mem_op),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .i_mem_ready (i_mem_ready),
    .i_mem_rdata (i_mem_rdata)
  );

endmodule

//--- test/tb_cache_subsys.sv
// ----------------------------------------
// cache subsystem testbench: line memory,
// tag model and sweep result checks
// ----------------------------------------
`timescale 1ns/1ps

module tb_cache_subsys import cache_pkg::*; ();

  localparam int                NUM_SETS  = 16;
  localparam logic [ADDR_W-1:0] BASE_ADDR = 64'h0000_0000_8000_0000;
  localparam int                NUM_WORDS = 512;
  localparam int                GAP       = 5;
  localparam int                SET_W     = $clog2(NUM_SETS);
  localparam int                LINE_SH   = OFFS_W + 3;        // bytes per line as shift
  localparam int                RUN_LIMIT = 100000;           // cycles per sweep
  localparam int                WB_LINES  = NUM_WORDS / 8 - NUM_SETS;   // evicted in pass 1

  logic              clk;
  logic              rst;
  logic              i_start;
  logic              o_mem_valid;
  logic              o_mem_op;
  logic [ADDR_W-1:0] o_mem_addr;
  logic [LINE_W-1:0] o_mem_wdata;
  logic              i_mem_ready;
  logic [LINE_W-1:0] i_mem_rdata;
  logic              o_busy;
  logic              o_done;
  logic              o_error;
  logic [ADDR_W-1:0] o_err_addr;

  // tag model and predicted line transactions
  bit                m_valid [NUM_SETS];
  bit                m_dirty [NUM_SETS];
  logic [ADDR_W-1:0] m_tag   [NUM_SETS];
  logic              exp_op   [$];
  logic [ADDR_W-1:0] exp_addr [$];

  logic [LINE_W-1:0] mem [logic [ADDR_W-1:0]];   // main memory with one entry per line
  bit                flip_armed;
  logic [ADDR_W-1:0] flip_addr;
  int                flip_word;
  logic [DATA_W-1:0] flip_mask;

  cache_subsys_top #(
    .NUM_SETS  (NUM_SETS),
    .BASE_ADDR (BASE_ADDR),
    .NUM_WORDS (NUM_WORDS),
    .GAP       (GAP)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .o_mem_valid (o_mem_valid),
    .o_mem_op    (o_mem_op),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .i_mem_ready (i_mem_ready),
    .i_mem_rdata (i_mem_rdata),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .o_error     (o_error),
    .o_err_addr  (o_err_addr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("Error at %0d ns: %s", $time, why);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  function automatic logic [LINE_W-1:0] random_line();
    logic [LINE_W-1:0] line;
    for (int i = 0; i < LINE_W / 32; i++)
      line[i*32 +: 32] = $urandom;
    return line;
  endfunction

  // one request through a direct-mapped write-back cache
  task automatic predict_access(input logic [ADDR_W-1:0] addr, input bit is_write);
    int                set;
    logic [ADDR_W-1:0] tag;
    set = int'((addr >> LINE_SH) % NUM_SETS);
    tag = addr >> (LINE_SH + SET_W);
    if (!(m_valid[set] && m_tag[set] == tag)) begin
      if (m_valid[set] && m_dirty[set]) begin
        exp_op.push_back(OP_WRITE);
        exp_addr.push_back((m_tag[set] << (LINE_SH + SET_W)) | (ADDR_W'(set) << LINE_SH));
      end
      exp_op.push_back(OP_READ);
      exp_addr.push_back(addr & ~((64'd1 << LINE_SH) - 1));
      m_valid[set] = 1'b1;
      m_tag[set]   = tag;
      m_dirty[set] = 1'b0;
    end
    if (is_write)
      m_dirty[set] = 1'b1;
  endtask

  // write and read back each word and then read the whole range again
  task automatic predict_run();
    logic [ADDR_W-1:0] addr;
    for (int i = 0; i < NUM_WORDS; i++) begin
      addr = BASE_ADDR + ADDR_W'(8 * i);
      predict_access(addr, 1'b1);
      predict_access(addr, 1'b0);
    end
    for (int i = 0; i < NUM_WORDS; i++)
      predict_access(BASE_ADDR + ADDR_W'(8 * i), 1'b0);
  endtask

  task automatic open_transaction();
    logic [ADDR_W-1:0] word_addr;
    if (exp_addr.size() == 0)
      abort_run("line transaction seen that the tag model did not predict");
    check_value("o_mem_op", o_mem_op, exp_op.pop_front());
    check_value("o_mem_addr", o_mem_addr, exp_addr.pop_front());
    if (o_mem_op == OP_WRITE) begin
      for (int w = 0; w < 8; w++) begin
        word_addr = o_mem_addr + ADDR_W'(8 * w);
        check_value("o_mem_wdata word", o_mem_wdata[w*DATA_W +: DATA_W],
                    PATTERN_HI | word_addr);
      end
    end
  endtask

  task automatic close_transaction();
    logic [LINE_W-1:0] line;
    if (o_mem_op == OP_WRITE) begin
      line = o_mem_wdata;
      if (flip_armed && o_mem_addr == flip_addr) begin
        line[flip_word*DATA_W +: DATA_W] = line[flip_word*DATA_W +: DATA_W] ^ flip_mask;
        flip_armed = 1'b0;   // corrupt only this copy
      end
      mem[o_mem_addr] = line;
    end else begin
      if (!mem.exists(o_mem_addr))
        mem[o_mem_addr] = random_line();
      i_mem_rdata = mem[o_mem_addr];
    end
    i_mem_ready = 1'b1;
  endtask

  // ready pulses for one cycle 0 to 7 cycles after valid
  task automatic respond_memory();
    bit in_txn;
    int delay;
    in_txn = 1'b0;
    delay  = 0;
    forever begin
      @(negedge clk);
      if (i_mem_ready) begin
        i_mem_ready = 1'b0;
      end else if (!rst && o_mem_valid) begin
        if (!in_txn) begin
          open_transaction();
          in_txn = 1'b1;
          delay  = $urandom % 8;
        end
        if (delay == 0) begin
          close_transaction();
          in_txn = 1'b0;
        end else begin
          delay--;
        end
      end
    end
  endtask

  task automatic start_sweep();
    @(negedge clk);
    i_start = 1'b1;
    @(negedge clk);
    i_start = 1'b0;
    check_value("o_busy", o_busy, 1);
  endtask

  task automatic wait_sweep_end();
    int cycles;
    cycles = 0;
    while (!o_done && !o_error) begin
      @(negedge clk);
      cycles++;
      if (cycles > RUN_LIMIT)
        abort_run("timeout: the exerciser raised neither done nor error");
    end
  endtask

  initial begin
    int seed;
    int idle_cycles;
    int flip_line;
    seed = 25655;
    void'($urandom(seed));
    rst         = 1'b1;
    i_start     = 1'b0;
    i_mem_ready = 1'b0;
    i_mem_rdata = '0;
    flip_armed  = 1'b0;
    flip_addr   = '0;
    flip_word   = 0;
    flip_mask   = '0;
    fork
      respond_memory();
    join_none
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // quiet outputs before start
    idle_cycles = 4 + $urandom % 29;
    repeat (idle_cycles) begin
      @(negedge clk);
      check_value("o_mem_valid", o_mem_valid, 0);
      check_value("o_busy", o_busy, 0);
      check_value("o_done", o_done, 0);
      check_value("o_error", o_error, 0);
    end

    // clean sweep with the model starting from an empty cache
    for (int s = 0; s < NUM_SETS; s++) begin
      m_valid[s] = 1'b0;
      m_dirty[s] = 1'b0;
      m_tag[s]   = '0;
    end
    predict_run();
    start_sweep();
    wait_sweep_end();
    check_value("o_done", o_done, 1);
    check_value("o_busy", o_busy, 0);
    check_value("o_error", o_error, 0);
    check_value("pending line transactions", exp_addr.size(), 0);

    // second sweep with one word corrupted after its write-back
    flip_line  = $urandom % WB_LINES;
    flip_word  = $urandom % 8;
    flip_mask  = 64'd1 << ($urandom % 64);
    flip_addr  = BASE_ADDR + (ADDR_W'(flip_line) << LINE_SH);
    flip_armed = 1'b1;
    predict_run();   // cache keeps its contents from the first sweep
    start_sweep();
    wait_sweep_end();
    check_value("write-back of corrupted line seen", flip_armed, 0);
    check_value("o_error", o_error, 1);
    check_value("o_done", o_done, 0);
    check_value("o_busy", o_busy, 0);
    check_value("o_err_addr", o_err_addr, flip_addr + ADDR_W'(8 * flip_word));

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- project.f
common/cache_pkg.sv
common/cache_if.sv
cache/cache_decode.sv
cache/cache_execute.sv
cache/cache_result.sv
cache/cache_core.sv
design/cache_exerciser.sv
design/cache_subsys_top.sv
test/tb_cache_subsys.sv
